// ==== Makefile ====
# Verilator build and run for the soc glue testbench

VERILATOR ?= verilator
TOP       ?= soc_glue_tb
RTL_TOP   ?= soc_glue_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := test passed
FAIL_MSG  := test failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG) || \
	   ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== all.f ====
rtl/soc_glue_pkg.sv
rtl/glue_ctrl.sv
rtl/mac_tx_path.sv
rtl/mac_rx_pack.sv
rtl/udp_test_source.sv
rtl/status_led.sv
rtl/soc_glue_top.sv
tb/soc_glue_props.sv
tb/soc_glue_tb.sv

// ==== rtl/glue_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module glue_ctrl import soc_glue_pkg::*; (
    input  wire logic     HCLK,
    input  wire logic     rst_key,
    input  wire ahb_req_t ahb_i,
    input  wire apb_req_t apb_i,
    input  wire logic     udp_cs_i,                    // udp engine wants the transmitter
    input  wire tx_beat_t granted_i,                   // beat of the current owner
    output logic          udp_hsel_o,
    output logic          mac_psel_o,
    output logic          mac_penable_o,
    output logic          udp_owner_o
);

    logic in_udp_region;
    logic in_mac_window;
    logic frame_busy;                                  // granted frame in flight
    logic hold_owner;

    // address decode, all combinational
    assign in_udp_region = (ahb_i.haddr[HADDR_W-1 -: 4] == UDP_REGION);
    assign in_mac_window = (apb_i.paddr < MAC_APB_LIMIT);

    assign udp_hsel_o    = ahb_i.hsel && in_udp_region;
    assign mac_psel_o    = apb_i.psel && in_mac_window;
    assign mac_penable_o = apb_i.penable && in_mac_window;

    // a frame opens on tstart and closes on tlast, both may share one beat
    always_ff @(posedge HCLK or negedge rst_key) begin
        if (!rst_key) begin
            frame_busy <= 1'b0;
        end else if (granted_i.tlast) begin
            frame_busy <= 1'b0;
        end else if (granted_i.tstart) begin
            frame_busy <= 1'b1;
        end
    end

    // keep the owner from the start beat up to and including the last beat
    assign hold_owner = (frame_busy || granted_i.tstart) && !granted_i.tlast;

    always_ff @(posedge HCLK or negedge rst_key) begin
        if (!rst_key) begin
            udp_owner_o <= 1'b0;                       // cpu owns after reset
        end else if (!hold_owner) begin
            udp_owner_o <= udp_cs_i;                   // switch only between frames
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mac_rx_pack.sv ====
`timescale 1ns/10ps
`default_nettype none

module mac_rx_pack import soc_glue_pkg::*; (
    input  wire logic     HCLK,
    input  wire logic     rst_key,
    input  wire rx_beat_t mac_rx_i,
    output rx_beat_t      cpu_rx_o
);

    rx_word_u rx_in;
    rx_word_u rx_masked;
    rx_word_u rx_q1;                                   // first stage
    rx_word_u rx_q2;                                   // second stage, seen by cpu

    assign rx_in.beat    = mac_rx_i;
    assign rx_masked.raw = {(BYTE_W+2){mac_rx_i.rvalid}} & rx_in.raw; // idle beats read as 0

    always_ff @(posedge HCLK or negedge rst_key) begin
        if (!rst_key) begin
            rx_q1.raw <= '0;
            rx_q2.raw <= '0;
        end else begin
            rx_q1.raw <= rx_masked.raw;
            rx_q2.raw <= rx_q1.raw;
        end
    end

    assign cpu_rx_o = rx_q2.beat;

endmodule

`default_nettype wire

// ==== rtl/mac_tx_path.sv ====
`timescale 1ns/10ps
`default_nettype none

module mac_tx_path import soc_glue_pkg::*; (
    input  wire logic     HCLK,
    input  wire logic     rst_key,
    input  wire logic     udp_owner_i,
    input  wire tx_beat_t cpu_beat_i,
    input  wire tx_beat_t udp_beat_i,
    input  wire logic     mac_tpnd_i,                  // mac still busy sending
    output tx_beat_t      mac_beat_o,
    output tx_beat_t      granted_o,
    output logic          cpu_tpnd_o,
    output logic          udp_tpnd_o
);

    // owner's beat, seen by the controller in the same cycle
    assign granted_o = udp_owner_i ? udp_beat_i : cpu_beat_i;

    always_ff @(posedge HCLK or negedge rst_key) begin
        if (!rst_key) begin
            mac_beat_o <= '0;
        end else begin
            mac_beat_o <= granted_o;                   // one cycle to the mac
        end
    end

    // pending goes back to whoever owns the port
    assign cpu_tpnd_o = mac_tpnd_i && !udp_owner_i;
    assign udp_tpnd_o = mac_tpnd_i && udp_owner_i;

endmodule

`default_nettype wire

// ==== rtl/soc_glue_pkg.sv ====
`default_nettype none

package soc_glue_pkg;

    localparam int BYTE_W  = 8;                        // mac data byte
    localparam int HADDR_W = 32;                       // ahb address
    localparam int PADDR_W = 12;                       // apb address

    localparam logic [3:0] UDP_REGION = 4'h7;          // haddr[31:28] of the udp engine
    localparam logic [PADDR_W-1:0] MAC_APB_LIMIT = 12'h300; // mac owns everything below

    localparam int unsigned HB_TICKS_DEFAULT = 33_000_000; // one second at 33 MHz
    localparam int HB_CNT_W = 27;

    // one transmit beat toward the mac
    typedef struct packed {
        logic [BYTE_W-1:0] tdata;
        logic              tstart;                     // first beat of a frame
        logic              tlast;                      // last beat of a frame
    } tx_beat_t;

    // receive beat, same bit order as the 10-bit cpu word
    typedef struct packed {
        logic              rlast;
        logic              rvalid;
        logic [BYTE_W-1:0] rdata;
    } rx_beat_t;

    typedef union packed {
        logic [BYTE_W+1:0] raw;                        // as moved through the registers
        rx_beat_t          beat;                       // as read by the cpu
    } rx_word_u;

    typedef struct packed {
        logic               hsel;
        logic [1:0]         htrans;
        logic               hwrite;
        logic [HADDR_W-1:0] haddr;
    } ahb_req_t;

    typedef struct packed {
        logic               psel;
        logic               penable;
        logic               pwrite;
        logic [PADDR_W-1:0] paddr;
    } apb_req_t;

endpackage

`default_nettype wire

// ==== rtl/soc_glue_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module soc_glue_top import soc_glue_pkg::*; #(
    parameter int unsigned HB_TICKS = HB_TICKS_DEFAULT
) (
    input  wire logic              HCLK,
    input  wire logic              rst_key,
    // cpu bus side
    input  wire ahb_req_t          ahb_i,
    input  wire apb_req_t          apb_i,
    output logic                   udp_hsel_o,
    output logic                   mac_psel_o,
    output logic                   mac_penable_o,
    // transmit
    input  wire tx_beat_t          cpu_beat_i,
    input  wire tx_beat_t          udp_beat_i,
    input  wire logic              udp_cs_i,
    input  wire logic              mac_tpnd_i,
    output tx_beat_t               mac_beat_o,
    output logic                   cpu_tpnd_o,
    output logic                   udp_tpnd_o,
    // receive
    input  wire rx_beat_t          mac_rx_i,
    output rx_beat_t               cpu_rx_o,
    // udp test data
    input  wire logic              dready_i,
    output logic      [BYTE_W-1:0] datai_o,
    output logic                   dbusy_o,
    // board leds
    input  wire logic        [1:0] gpio_out_i,
    input  wire logic        [1:0] gpio_outen_i,
    input  wire logic              init_done_i,
    output logic             [3:0] led_o
);

    logic     udp_owner;                               // 1 while udp engine owns tx
    tx_beat_t granted_beat;

    glue_ctrl u_glue_ctrl (
        .HCLK          (HCLK),
        .rst_key       (rst_key),
        .ahb_i         (ahb_i),
        .apb_i         (apb_i),
        .udp_cs_i      (udp_cs_i),
        .granted_i     (granted_beat),
        .udp_hsel_o    (udp_hsel_o),
        .mac_psel_o    (mac_psel_o),
        .mac_penable_o (mac_penable_o),
        .udp_owner_o   (udp_owner)
    );

    mac_tx_path u_mac_tx_path (
        .HCLK          (HCLK),
        .rst_key       (rst_key),
        .udp_owner_i   (udp_owner),
        .cpu_beat_i    (cpu_beat_i),
        .udp_beat_i    (udp_beat_i),
        .mac_tpnd_i    (mac_tpnd_i),
        .mac_beat_o    (mac_beat_o),
        .granted_o     (granted_beat),
        .cpu_tpnd_o    (cpu_tpnd_o),
        .udp_tpnd_o    (udp_tpnd_o)
    );

    mac_rx_pack u_mac_rx_pack (
        .HCLK          (HCLK),
        .rst_key       (rst_key),
        .mac_rx_i      (mac_rx_i),
        .cpu_rx_o      (cpu_rx_o)
    );

    udp_test_source u_udp_test_source (
        .HCLK          (HCLK),
        .rst_key       (rst_key),
        .dready_i      (dready_i),
        .datai_o       (datai_o),
        .dbusy_o       (dbusy_o)
    );

    status_led #(
        .HB_TICKS      (HB_TICKS)
    ) u_status_led (
        .HCLK          (HCLK),
        .rst_key       (rst_key),
        .gpio_out_i    (gpio_out_i),
        .gpio_outen_i  (gpio_outen_i),
        .init_done_i   (init_done_i),
        .led_o         (led_o)
    );

endmodule

`default_nettype wire

// ==== rtl/status_led.sv ====
`timescale 1ns/10ps
`default_nettype none

module status_led import soc_glue_pkg::*; #(
    parameter int unsigned HB_TICKS = HB_TICKS_DEFAULT
) (
    input  wire logic       HCLK,
    input  wire logic       rst_key,
    input  wire logic [1:0] gpio_out_i,
    input  wire logic [1:0] gpio_outen_i,
    input  wire logic       init_done_i,               // memory init finished
    output logic      [3:0] led_o
);

    logic [HB_CNT_W-1:0] hb_cnt;
    logic                hb_wrap;
    logic                hb_led;

    assign hb_wrap = (hb_cnt >= HB_CNT_W'(HB_TICKS));

    always_ff @(posedge HCLK or negedge rst_key) begin
        if (!rst_key) begin
            hb_cnt <= '0;
        end else if (hb_wrap) begin
            hb_cnt <= '0;
        end else begin
            hb_cnt <= hb_cnt + 1'b1;
        end
    end

    always_ff @(posedge HCLK or negedge rst_key) begin
        if (!rst_key) begin
            hb_led <= 1'b1;                            // led starts lit
        end else if (hb_wrap) begin
            hb_led <= !hb_led;
        end
    end

    assign led_o[1:0] = gpio_out_i & gpio_outen_i;     // only driven pins light up
    assign led_o[2]   = init_done_i;
    assign led_o[3]   = hb_led;

endmodule

`default_nettype wire

// ==== rtl/udp_test_source.sv ====
`timescale 1ns/10ps
`default_nettype none

module udp_test_source import soc_glue_pkg::*; (
    input  wire logic         HCLK,
    input  wire logic         rst_key,
    input  wire logic         dready_i,                // udp engine ready for data
    output logic [BYTE_W-1:0] datai_o,
    output logic              dbusy_o                  // datai_o is valid
);

    always_ff @(posedge HCLK or negedge rst_key) begin
        if (!rst_key) begin
            datai_o <= '0;
            dbusy_o <= 1'b0;
        end else if (dready_i) begin
            datai_o <= datai_o + 1'b1;                 // wraps at 256
            dbusy_o <= 1'b1;
        end else begin
            // pattern restarts from zero on the next ready run
            datai_o <= '0;
            dbusy_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== tb/soc_glue_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module soc_glue_props import soc_glue_pkg::*; (
    input wire logic     HCLK,
    input wire logic     rst_key,
    input wire ahb_req_t ahb_i,
    input wire logic     udp_hsel_o,
    input wire logic     cpu_tpnd_o,
    input wire logic     udp_tpnd_o,
    input wire rx_beat_t mac_rx_i,
    input wire rx_beat_t cpu_rx_o,
    input wire tx_beat_t granted_beat,
    input wire logic     udp_owner
);

    int   n_excl  = 0;
    int   n_hsel  = 0;
    int   n_rx    = 0;
    int   n_owner = 0;
    int   fail_cnt;
    logic in_frame;                                        // granted frame seen open

    assign fail_cnt = n_excl + n_hsel + n_rx + n_owner;

    always_ff @(posedge HCLK or negedge rst_key) begin
        if (!rst_key) begin
            in_frame <= 1'b0;
        end else if (granted_beat.tlast) begin
            in_frame <= 1'b0;
        end else if (granted_beat.tstart) begin
            in_frame <= 1'b1;
        end
    end

    a_tpnd_excl: assert property (@(posedge HCLK) disable iff (!rst_key)
        !(cpu_tpnd_o && udp_tpnd_o))
        else begin n_excl++; $error("pending flag routed to both sources"); end

    a_hsel: assert property (@(posedge HCLK) disable iff (!rst_key)
        udp_hsel_o |-> (ahb_i.hsel && ahb_i.haddr[HADDR_W-1 -: 4] == UDP_REGION))
        else begin n_hsel++; $error("udp_hsel outside the udp region"); end

    a_rx_zero: assert property (@(posedge HCLK) disable iff (!rst_key)
        !$past(mac_rx_i.rvalid, 2) |-> (cpu_rx_o == '0))
        else begin n_rx++; $error("receive word not zero after an idle beat"); end

    a_owner: assert property (@(posedge HCLK) disable iff (!rst_key)
        ((in_frame || granted_beat.tstart) && !granted_beat.tlast) |=> $stable(udp_owner))
        else begin n_owner++; $error("tx owner changed inside a frame"); end

endmodule

bind soc_glue_top soc_glue_props u_props (
    .HCLK         (HCLK),
    .rst_key      (rst_key),
    .ahb_i        (ahb_i),
    .udp_hsel_o   (udp_hsel_o),
    .cpu_tpnd_o   (cpu_tpnd_o),
    .udp_tpnd_o   (udp_tpnd_o),
    .mac_rx_i     (mac_rx_i),
    .cpu_rx_o     (cpu_rx_o),
    .granted_beat (granted_beat),
    .udp_owner    (udp_owner)
);

`default_nettype wire

// ==== tb/soc_glue_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module soc_glue_tb import soc_glue_pkg::*; ();

    localparam int unsigned HB_TICKS  = 20;
    localparam int          HB_PERIOD = HB_TICKS + 1;      // cycles between led toggles
    localparam int          LED_WAIT_LIMIT = 3 * HB_PERIOD;
    localparam int unsigned SEED = 32'he2c5_60bc;
    localparam tx_beat_t    NO_BEAT = '0;

    // one table row is one clock cycle of stimulus plus what it should produce
    typedef struct packed {
        logic        hsel;
        logic [31:0] haddr;
        logic        psel;
        logic        penable;
        logic [11:0] paddr;
        tx_beat_t    cpu_beat;
        tx_beat_t    udp_beat;
        logic        udp_cs;
        logic        tpnd;
        rx_beat_t    rx;
        logic        dready;
        logic [1:0]  gpio_out;
        logic [1:0]  gpio_en;
        logic        init_done;
        logic        exp_owner;                            // tx owner during this cycle
        logic        exp_hsel;
        logic        exp_psel;
        logic        exp_pen;
    } row_t;

    logic        HCLK;
    logic        rst_key;
    ahb_req_t    ahb;
    apb_req_t    apb;
    tx_beat_t    cpu_beat;
    tx_beat_t    udp_beat;
    logic        udp_cs;
    logic        mac_tpnd;
    rx_beat_t    mac_rx;
    logic        dready;
    logic [1:0]  gpio_out;
    logic [1:0]  gpio_en;
    logic        init_done;
    logic        udp_hsel;
    logic        mac_psel;
    logic        mac_penable;
    tx_beat_t    mac_beat;
    logic        cpu_tpnd;
    logic        udp_tpnd;
    rx_beat_t    cpu_rx;
    logic [7:0]  datai;
    logic        dbusy;
    logic [3:0]  led;

    row_t        rows[$];
    int          n_checks = 0;
    int          n_errors = 0;
    int          n_timeouts = 0;
    int          edge_cnt = 0;                             // edges since reset release
    int          ready_run = 0;                            // consecutive dready edges

    soc_glue_top #(.HB_TICKS(HB_TICKS)) DUT (
        .HCLK(HCLK), .rst_key(rst_key),
        .ahb_i(ahb), .apb_i(apb),
        .udp_hsel_o(udp_hsel), .mac_psel_o(mac_psel), .mac_penable_o(mac_penable),
        .cpu_beat_i(cpu_beat), .udp_beat_i(udp_beat), .udp_cs_i(udp_cs),
        .mac_tpnd_i(mac_tpnd), .mac_beat_o(mac_beat),
        .cpu_tpnd_o(cpu_tpnd), .udp_tpnd_o(udp_tpnd),
        .mac_rx_i(mac_rx), .cpu_rx_o(cpu_rx),
        .dready_i(dready), .datai_o(datai), .dbusy_o(dbusy),
        .gpio_out_i(gpio_out), .gpio_outen_i(gpio_en), .init_done_i(init_done),
        .led_o(led)
    );

    initial begin
        HCLK = 1'b0;
        forever #2 HCLK = ~HCLK;                           // 4 ns period
    end

    always @(posedge HCLK) begin
        if (rst_key) edge_cnt <= edge_cnt + 1;
    end

    function automatic tx_beat_t make_beat(input logic [7:0] data, input logic start,
                                           input logic last);
        tx_beat_t b;
        b.tdata  = data;
        b.tstart = start;
        b.tlast  = last;
        return b;
    endfunction

    task automatic add_decode(input logic hsel, input logic [31:0] haddr, input logic psel,
                              input logic pen, input logic [11:0] paddr, input logic [2:0] exp);
        row_t r;
        r = '0;
        r.hsel    = hsel;
        r.haddr   = haddr;
        r.psel    = psel;
        r.penable = pen;
        r.paddr   = paddr;
        {r.exp_hsel, r.exp_psel, r.exp_pen} = exp;
        rows.push_back(r);
    endtask

    task automatic add_tx(input tx_beat_t cpu_b, input tx_beat_t udp_b, input logic cs,
                          input logic tpnd, input logic owner);
        row_t r;
        r = '0;
        r.cpu_beat  = cpu_b;
        r.udp_beat  = udp_b;
        r.udp_cs    = cs;
        r.tpnd      = tpnd;
        r.exp_owner = owner;
        rows.push_back(r);
    endtask

    task automatic add_rx(input logic valid, input logic last);
        row_t r;
        r = '0;
        r.rx.rdata  = 8'($urandom);                        // data kept even when idle
        r.rx.rvalid = valid;
        r.rx.rlast  = last;
        rows.push_back(r);
    endtask

    task automatic add_src(input logic ready);
        row_t r;
        r = '0;
        r.dready = ready;
        rows.push_back(r);
    endtask

    task automatic add_led(input logic [4:0] v);
        row_t r;
        r = '0;
        r.gpio_out  = v[1:0];
        r.gpio_en   = v[3:2];
        r.init_done = v[4];
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_decode(1'b1, 32'h7000_0040, 1'b1, 1'b0, 12'h100, 3'b110);
        add_decode(1'b1, 32'h7fff_fffc, 1'b1, 1'b1, 12'h2ff, 3'b111);
        add_decode(1'b0, 32'h7000_0000, 1'b1, 1'b1, 12'h300, 3'b000);
        add_decode(1'b1, 32'h6fff_ffff, 1'b0, 1'b1, 12'h000, 3'b001);
        add_decode(1'b1, 32'h8000_0000, 1'b1, 1'b1, 12'hfff, 3'b000);
        add_decode(1'b0, 32'h0000_0000, 1'b0, 1'b0, 12'h000, 3'b000);
        // cpu frame, udp_cs rises in the middle and waits for tlast
        add_tx(make_beat(8'ha1, 1'b1, 1'b0), NO_BEAT, 1'b0, 1'b1, 1'b0);
        add_tx(make_beat(8'ha2, 1'b0, 1'b0), make_beat(8'h55, 1'b1, 1'b0), 1'b1, 1'b1, 1'b0);
        add_tx(make_beat(8'ha3, 1'b0, 1'b1), make_beat(8'h56, 1'b0, 1'b1), 1'b1, 1'b0, 1'b0);
        add_tx(make_beat(8'hc0, 1'b1, 1'b1), make_beat(8'hb1, 1'b1, 1'b0), 1'b1, 1'b1, 1'b1);
        add_tx(NO_BEAT, make_beat(8'hb2, 1'b0, 1'b1), 1'b0, 1'b0, 1'b1);
        // single beat cpu frame, then a three beat udp frame
        add_tx(make_beat(8'hc1, 1'b1, 1'b1), NO_BEAT, 1'b1, 1'b1, 1'b0);
        add_tx(make_beat(8'hc2, 1'b1, 1'b0), make_beat(8'hd1, 1'b1, 1'b0), 1'b0, 1'b1, 1'b1);
        add_tx(NO_BEAT, make_beat(8'hd2, 1'b0, 1'b0), 1'b0, 1'b1, 1'b1);
        add_tx(NO_BEAT, make_beat(8'hd3, 1'b0, 1'b1), 1'b0, 1'b0, 1'b1);
        add_tx(NO_BEAT, NO_BEAT, 1'b0, 1'b1, 1'b0);
        add_tx(NO_BEAT, NO_BEAT, 1'b0, 1'b0, 1'b0);
        add_rx(1'b1, 1'b0);
        add_rx(1'b1, 1'b0);
        add_rx(1'b0, 1'b1);                                // must come out as zero
        add_rx(1'b1, 1'b1);
        add_rx(1'b0, 1'b0);
        add_rx(1'b1, 1'b0);
        add_src(1'b1);
        add_src(1'b1);
        add_src(1'b1);
        add_src(1'b0);
        add_src(1'b1);
        add_src(1'b0);
        add_src(1'b0);
        repeat (258) add_src(1'b1);                        // long enough to wrap the byte
        add_src(1'b0);
        add_src(1'b0);
        for (int v = 0; v < 32; v++) add_led(5'(v));
    endtask

    task automatic drive_row(input row_t r);
        ahb.hsel    = r.hsel;
        ahb.htrans  = r.hsel ? 2'b10 : 2'b00;              // nonseq while selected
        ahb.hwrite  = 1'b0;
        ahb.haddr   = r.haddr;
        apb.psel    = r.psel;
        apb.penable = r.penable;
        apb.pwrite  = 1'b0;
        apb.paddr   = r.paddr;
        cpu_beat    = r.cpu_beat;
        udp_beat    = r.udp_beat;
        udp_cs      = r.udp_cs;
        mac_tpnd    = r.tpnd;
        mac_rx      = r.rx;
        dready      = r.dready;
        gpio_out    = r.gpio_out;
        gpio_en     = r.gpio_en;
        init_done   = r.init_done;
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        n_checks++;
        assert (act === exp) else begin
            n_errors++;
            $display("Fail at %0d ns: %s expected %0h, got %0h", $time, name, exp, act);
        end
    endtask

    task automatic check_row(input int i);
        row_t       cur;
        row_t       prev1;
        row_t       prev2;
        tx_beat_t   exp_beat;
        rx_beat_t   exp_rx;
        logic [3:0] exp_led;
        cur   = rows[i];
        prev1 = '0;                                        // idle inputs before the table
        prev2 = '0;
        if (i >= 1) prev1 = rows[i-1];
        if (i >= 2) prev2 = rows[i-2];
        exp_beat = prev1.exp_owner ? prev1.udp_beat : prev1.cpu_beat;
        exp_rx   = prev2.rx.rvalid ? prev2.rx : '0;
        exp_led[1:0] = cur.gpio_out & cur.gpio_en;
        exp_led[2]   = cur.init_done;
        exp_led[3]   = ((edge_cnt / HB_PERIOD) % 2) == 0;
        check_val("udp_hsel_o", 32'(cur.exp_hsel), 32'(udp_hsel));
        check_val("mac_psel_o", 32'(cur.exp_psel), 32'(mac_psel));
        check_val("mac_penable_o", 32'(cur.exp_pen), 32'(mac_penable));
        check_val("mac_beat_o", 32'(exp_beat), 32'(mac_beat));
        check_val("cpu_tpnd_o", 32'(cur.tpnd && !cur.exp_owner), 32'(cpu_tpnd));
        check_val("udp_tpnd_o", 32'(cur.tpnd && cur.exp_owner), 32'(udp_tpnd));
        check_val("cpu_rx_o", 32'(exp_rx), 32'(cpu_rx));
        check_val("datai_o", 32'(ready_run % 256), 32'(datai));
        check_val("dbusy_o", 32'(ready_run != 0), 32'(dbusy));
        check_val("led_o", 32'(exp_led), 32'(led));
        ready_run = cur.dready ? ready_run + 1 : 0;
    endtask

    // called just after a sample point, returns cycles until led 3 changes
    task automatic wait_led3_change(output int cycles, output logic seen);
        logic start_val;
        start_val = led[3];
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < LED_WAIT_LIMIT) begin
            @(posedge HCLK);
            #3;
            cycles++;
            if (led[3] !== start_val) seen = 1'b1;
        end
        if (!seen) begin
            n_timeouts++;
            $display("Timeout: heartbeat LED did not toggle within %0d cycles", LED_WAIT_LIMIT);
        end
    endtask

    initial begin
        int          c0;
        int          c1;
        logic        ok0;
        logic        ok1;
        int          prop_fails;
        void'($urandom(SEED));
        rst_key = 1'b0;
        drive_row('0);
        build_table();
        repeat (8) @(posedge HCLK);
        #1 rst_key = 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge HCLK);
            #1;
            drive_row(rows[i]);
            #2;
            check_row(i);
        end
        wait_led3_change(c0, ok0);                         // align to a toggle first
        wait_led3_change(c1, ok1);
        if (ok0 && ok1) check_val("heartbeat period", 32'(HB_PERIOD), 32'(c1));
        prop_fails = DUT.u_props.fail_cnt;
        $display("checks %0d, value errors %0d, timeouts %0d, assertion failures %0d",
                 n_checks, n_errors, n_timeouts, prop_fails);
        if (n_errors == 0 && n_timeouts == 0 && prop_fails == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
